/* run.sh */
#!/usr/bin/env bash
# compile and run the dcache testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f sources.f

./obj_dir/Vdcache_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sources.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_store.sv
src/dcache_line_store.sv
src/dcache_uncached_path.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_props.sv
test/dcache_tb.sv

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // cpu request, held until the completion pulse
  input  logic [`DC_XLEN-1:0]   mem_addr_i,
  input  mem_size_e             mem_size_i,
  input  logic                  mem_addr_valid_i,
  input  logic                  mem_write_valid_i,
  input  logic [`DC_XLEN-1:0]   mem_wdata_i,
  // from uncached path
  input  logic                  uncached_i,
  input  logic [3:0]            unc_wstrb_i,
  input  logic [`DC_XLEN-1:0]   unc_rdata_i,
  // from tag store
  input  logic                  hit_i,
  input  logic                  dirty_i,
  input  logic [`DC_TAG_W-1:0]  victim_tag_i,
  // memory port handshakes
  input  logic                  arb_rvalid_i,
  input  logic                  arb_wready_i,
  output dcache_state_e         state_o,
  output logic [`DC_BEAT_W-1:0] beat_o,
  output logic                  tag_we_o,
  output logic                  dirty_set_o,
  output logic                  line_we_o,
  output logic                  refill_o,
  output logic [`DC_XLEN-1:0]   unc_rdata_o,
  output logic [`DC_XLEN-1:0]   unc_wdata_o,  // registered uncached write word
  output logic                  mem_data_ready_o,
  output logic [`DC_XLEN-1:0]   arb_araddr_o,
  output logic                  arb_arvalid_o,
  output logic [3:0]            arb_rsize_o,
  output logic [7:0]            arb_rlen_o,
  output logic [`DC_XLEN-1:0]   arb_awaddr_o,
  output logic                  arb_awvalid_o,
  output logic [3:0]            arb_wmask_o,
  output logic [3:0]            arb_wsize_o,
  output logic [7:0]            arb_wlen_o
);

  dcache_state_e         state_q;
  logic [`DC_BEAT_W-1:0] beat_q;
  logic                  ready_q;
  logic                  arvalid_q;
  logic                  awvalid_q;

  logic [`DC_XLEN-1:0] line_addr;    // request line, offset cleared
  logic [`DC_XLEN-1:0] victim_addr;  // old line at the same index
  logic                req_ok;
  logic                wr_hit;
  logic                rd_hs;
  logic                wr_hs;
  logic                last_beat;

  assign line_addr   = {mem_addr_i[`DC_XLEN-1:`DC_OFS_W], {`DC_OFS_W{1'b0}}};
  assign victim_addr = {victim_tag_i, mem_addr_i[`DC_OFS_W +: `DC_IDX_W], {`DC_OFS_W{1'b0}}};

  // no new accept while the pulse is out, so one completion per access
  assign req_ok    = (state_q == ST_IDLE) && mem_addr_valid_i && !ready_q;
  assign wr_hit    = req_ok && !uncached_i && hit_i && mem_write_valid_i;
  assign rd_hs     = arvalid_q && arb_rvalid_i;  // one beat per cycle
  assign wr_hs     = awvalid_q && arb_wready_i;
  assign last_beat = (beat_q == `DC_BEAT_W'(`DC_BURST_LEN));

  // store side controls
  assign refill_o    = (state_q == ST_REFILL);
  assign line_we_o   = wr_hit || (refill_o && rd_hs);
  assign tag_we_o    = wr_hit || (refill_o && rd_hs && last_beat);  // tag lands with last beat
  assign dirty_set_o = wr_hit;  // refill leaves the line clean

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_RST;
      beat_q    <= '0;
      ready_q   <= 1'b0;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;  // single cycle pulse
      case (state_q)
        ST_RST: state_q <= ST_IDLE;
        ST_IDLE: begin
          if (req_ok) begin
            if (uncached_i) begin
              if (mem_write_valid_i) begin
                state_q   <= ST_UNC_WRITE;
                awvalid_q <= 1'b1;
              end else begin
                state_q   <= ST_UNC_READ;
                arvalid_q <= 1'b1;
              end
            end else if (hit_i) begin
              ready_q <= 1'b1;  // read or write hit done
            end else if (dirty_i) begin
              state_q   <= ST_WRITE_BACK;  // victim first
              awvalid_q <= 1'b1;
              beat_q    <= '0;
            end else begin
              state_q   <= ST_REFILL;
              arvalid_q <= 1'b1;
              beat_q    <= '0;
            end
          end
        end
        ST_WRITE_BACK: begin
          if (wr_hs) begin
            if (last_beat) begin
              state_q   <= ST_REFILL;  // straight into the refill
              awvalid_q <= 1'b0;
              arvalid_q <= 1'b1;
              beat_q    <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_REFILL: begin
          if (rd_hs) begin
            if (last_beat) begin
              state_q   <= ST_IDLE;  // held request then hits
              arvalid_q <= 1'b0;
              beat_q    <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_UNC_READ: begin
          if (rd_hs) begin
            state_q   <= ST_IDLE;
            arvalid_q <= 1'b0;
            ready_q   <= 1'b1;
          end
        end
        ST_UNC_WRITE: begin
          if (wr_hs) begin
            state_q   <= ST_IDLE;
            awvalid_q <= 1'b0;
            ready_q   <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // memory port payload, loaded when a transfer starts
  always_ff @(posedge clk) begin
    if (req_ok && uncached_i) begin
      arb_araddr_o <= mem_addr_i;  // exact byte address
      arb_rsize_o  <= mem_size_i;
      arb_rlen_o   <= 8'd0;        // single beat
      arb_awaddr_o <= mem_addr_i;
      arb_wsize_o  <= mem_size_i;
      arb_wlen_o   <= 8'd0;
      arb_wmask_o  <= unc_wstrb_i;
      unc_wdata_o  <= mem_wdata_i;
    end else if (req_ok && !hit_i) begin
      arb_araddr_o <= line_addr;
      arb_rsize_o  <= SIZE_WORD;
      arb_rlen_o   <= 8'(`DC_BURST_LEN);
      arb_awaddr_o <= victim_addr;
      arb_wsize_o  <= SIZE_WORD;
      arb_wlen_o   <= 8'(`DC_BURST_LEN);
      arb_wmask_o  <= 4'b1111;  // whole words on write back
    end
    if ((state_q == ST_UNC_READ) && rd_hs) begin
      unc_rdata_o <= unc_rdata_i;  // extracted lane, kept for the pulse
    end
  end

  assign state_o          = state_q;
  assign beat_o           = beat_q;
  assign mem_data_ready_o = ready_q;
  assign arb_arvalid_o    = arvalid_q;
  assign arb_awvalid_o    = awvalid_q;

endmodule

/* src/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and data width
`define DC_XLEN 32

// address split {tag, index, offset}
`define DC_OFS_W 6   // byte offset in a 64 byte line
`define DC_IDX_W 7   // line index
`define DC_TAG_W 19  // 32 - 7 - 6

// line geometry
`define DC_LINES 128  // direct mapped, one line per index
`define DC_BEATS 16   // 32 bit words per line

// burst counter and len code
`define DC_BEAT_W    4
`define DC_BURST_LEN 15  // beats minus one, as seen on the len ports

// everything from here up bypasses the cache
`define DC_UNCACHED_BASE 32'hA000_0000

`endif

/* src/dcache_line_store.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_line_store (
  input  logic                  clk,
  input  logic [`DC_IDX_W-1:0]  index_i,
  input  logic [`DC_BEAT_W-1:0] word_i,         // word within the line, from the address
  input  logic [`DC_BEAT_W-1:0] beat_i,         // burst position
  input  logic                  refill_i,
  input  logic                  we_i,
  input  logic [3:0]            wmask_i,        // byte lanes of a cpu write
  input  logic [`DC_XLEN-1:0]   wdata_i,
  input  logic [`DC_XLEN-1:0]   refill_data_i,  // beat from memory
  output logic [`DC_XLEN-1:0]   rdata_o,
  output logic [`DC_XLEN-1:0]   victim_data_o
);

  // word organized data array
  logic [`DC_XLEN-1:0] data_q [`DC_LINES][`DC_BEATS];

  always_ff @(posedge clk) begin
    if (we_i) begin
      if (refill_i) begin
        data_q[index_i][beat_i] <= refill_data_i;  // full word per beat
      end else begin
        // byte merge for write hits
        for (int b = 0; b < 4; b++) begin
          if (wmask_i[b]) begin
            data_q[index_i][word_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // cpu side read
  assign rdata_o = data_q[index_i][word_i];

  // write back read, steps with the burst count
  assign victim_data_o = data_q[index_i][beat_i];

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

  // controller states
  typedef enum logic [2:0] {
    ST_RST,         // one cycle after reset
    ST_IDLE,        // accepts requests, serves hits
    ST_WRITE_BACK,  // dirty victim goes out
    ST_REFILL,      // line comes in
    ST_UNC_READ,    // single beat read
    ST_UNC_WRITE    // single beat write
  } dcache_state_e;

  // access size codes, bytes per access
  typedef enum logic [3:0] {
    SIZE_BYTE = 4'd1,
    SIZE_HALF = 4'd2,
    SIZE_WORD = 4'd4
  } mem_size_e;

endpackage

/* src/dcache_tag_store.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_store (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`DC_IDX_W-1:0] index_i,
  input  logic [`DC_TAG_W-1:0] tag_i,        // request tag
  input  logic                 tag_we_i,
  input  logic                 dirty_set_i,  // dirty value stored with the tag
  output logic                 hit_o,
  output logic                 dirty_o,
  output logic [`DC_TAG_W-1:0] victim_tag_o
);

  // per line status bits
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  // tags only meaningful where valid
  logic [`DC_TAG_W-1:0] tag_q [`DC_LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;  // whole cache empty
      dirty_q <= '0;
    end else if (tag_we_i) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= dirty_set_i;  // refill writes clean, write hit dirty
    end
  end

  // tag written along with the status bits
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_q[index_i] <= tag_i;
    end
  end

  // combinational lookup at the current index
  logic line_valid;

  assign line_valid   = valid_q[index_i];
  assign victim_tag_o = tag_q[index_i];  // old owner of this index
  assign hit_o        = line_valid && (tag_q[index_i] == tag_i);
  assign dirty_o      = line_valid && dirty_q[index_i];  // only a valid line needs write back

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  // cpu port
  input  logic [`DC_XLEN-1:0] mem_addr_i,
  input  logic [3:0]          mem_mask_i,
  input  mem_size_e           mem_size_i,
  input  logic                mem_addr_valid_i,
  input  logic                mem_write_valid_i,
  input  logic [`DC_XLEN-1:0] mem_wdata_i,
  output logic [`DC_XLEN-1:0] mem_rdata_o,
  output logic                mem_data_ready_o,
  // memory read channel
  output logic [`DC_XLEN-1:0] arb_araddr_o,
  output logic                arb_arvalid_o,
  output logic [3:0]          arb_rsize_o,
  output logic [7:0]          arb_rlen_o,
  input  logic                arb_rvalid_i,
  input  logic [`DC_XLEN-1:0] arb_rdata_i,
  // memory write channel
  output logic [`DC_XLEN-1:0] arb_awaddr_o,
  output logic                arb_awvalid_o,
  output logic [3:0]          arb_wmask_o,
  output logic [3:0]          arb_wsize_o,
  output logic [7:0]          arb_wlen_o,
  input  logic                arb_wready_i,
  output logic [`DC_XLEN-1:0] arb_wdata_o
);

  // address fields
  logic [`DC_TAG_W-1:0]  req_tag;
  logic [`DC_IDX_W-1:0]  req_idx;
  logic [`DC_BEAT_W-1:0] req_word;

  assign req_tag  = mem_addr_i[`DC_XLEN-1 -: `DC_TAG_W];
  assign req_idx  = mem_addr_i[`DC_OFS_W +: `DC_IDX_W];
  assign req_word = mem_addr_i[2 +: `DC_BEAT_W];  // word within line

  dcache_state_e         state;
  logic [`DC_BEAT_W-1:0] beat;
  logic                  uncached;
  logic [3:0]            unc_wstrb;
  logic [`DC_XLEN-1:0]   unc_rdata_comb;  // extracted lane, live
  logic [`DC_XLEN-1:0]   unc_rdata_q;     // latched at the handshake
  logic [`DC_XLEN-1:0]   unc_wdata;
  logic                  hit;
  logic                  dirty;
  logic [`DC_TAG_W-1:0]  victim_tag;
  logic                  tag_we;
  logic                  dirty_set;
  logic                  line_we;
  logic                  refill;
  logic [`DC_XLEN-1:0]   line_rdata;
  logic [`DC_XLEN-1:0]   victim_data;

  dcache_ctrl u_ctrl (
    .clk, .rst, .mem_addr_i, .mem_size_i, .mem_addr_valid_i, .mem_write_valid_i,
    .mem_wdata_i, .uncached_i(uncached), .unc_wstrb_i(unc_wstrb),
    .unc_rdata_i(unc_rdata_comb), .hit_i(hit), .dirty_i(dirty), .victim_tag_i(victim_tag),
    .arb_rvalid_i, .arb_wready_i, .state_o(state), .beat_o(beat), .tag_we_o(tag_we),
    .dirty_set_o(dirty_set), .line_we_o(line_we), .refill_o(refill),
    .unc_rdata_o(unc_rdata_q), .unc_wdata_o(unc_wdata), .mem_data_ready_o,
    .arb_araddr_o, .arb_arvalid_o, .arb_rsize_o, .arb_rlen_o, .arb_awaddr_o,
    .arb_awvalid_o, .arb_wmask_o, .arb_wsize_o, .arb_wlen_o
  );

  dcache_tag_store u_tag_store (
    .clk, .rst, .index_i(req_idx), .tag_i(req_tag), .tag_we_i(tag_we),
    .dirty_set_i(dirty_set), .hit_o(hit), .dirty_o(dirty), .victim_tag_o(victim_tag)
  );

  dcache_line_store u_line_store (
    .clk, .index_i(req_idx), .word_i(req_word), .beat_i(beat), .refill_i(refill),
    .we_i(line_we), .wmask_i(mem_mask_i), .wdata_i(mem_wdata_i),
    .refill_data_i(arb_rdata_i), .rdata_o(line_rdata), .victim_data_o(victim_data)
  );

  dcache_uncached_path u_uncached_path (
    .addr_i(mem_addr_i), .size_i(mem_size_i), .mem_rdata_i(arb_rdata_i),
    .uncached_o(uncached), .wstrb_o(unc_wstrb), .rdata_o(unc_rdata_comb)
  );

  // cpu read data by region
  assign mem_rdata_o = uncached ? unc_rdata_q : line_rdata;

  // victim word follows the beat count during write back
  assign arb_wdata_o = (state == ST_WRITE_BACK) ? victim_data : unc_wdata;

endmodule

/* src/dcache_uncached_path.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_uncached_path import dcache_pkg::*; (
  input  logic [`DC_XLEN-1:0] addr_i,
  input  mem_size_e           size_i,
  input  logic [`DC_XLEN-1:0] mem_rdata_i,  // raw word from the memory port
  output logic                uncached_o,
  output logic [3:0]          wstrb_o,
  output logic [`DC_XLEN-1:0] rdata_o       // zero extended lane
);

  // io region at the top of the map
  assign uncached_o = (addr_i >= `DC_UNCACHED_BASE);

  // write lane strobe from size and low address bits
  always_comb begin
    case (size_i)
      SIZE_BYTE: wstrb_o = 4'b0001 << addr_i[1:0];
      SIZE_HALF: wstrb_o = addr_i[1] ? 4'b1100 : 4'b0011;
      default:   wstrb_o = 4'b1111;  // word and odd codes
    endcase
  end

  // lane extraction for reads
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign rd_byte = mem_rdata_i[8*addr_i[1:0] +: 8];
  assign rd_half = addr_i[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

  always_comb begin
    case (size_i)
      SIZE_BYTE: rdata_o = {24'b0, rd_byte};
      SIZE_HALF: rdata_o = {16'b0, rd_half};
      default:   rdata_o = mem_rdata_i;  // whole word
    endcase
  end

endmodule

/* test/dcache_props.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_props import dcache_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input dcache_state_e         state_o,
  input logic [`DC_BEAT_W-1:0] beat_o,
  input logic                  arb_arvalid_o,
  input logic                  arb_awvalid_o,
  input logic                  arb_rvalid_i,
  input logic                  arb_wready_i,
  input logic                  mem_data_ready_o
);

  logic last_count;
  logic rd_end;
  logic wr_end;

  assign last_count = (beat_o == `DC_BEAT_W'(`DC_BURST_LEN));
  // final beat of a burst, or the single uncached beat
  assign rd_end = arb_rvalid_i && (last_count || (state_o == ST_UNC_READ));
  assign wr_end = arb_wready_i && (last_count || (state_o == ST_UNC_WRITE));

  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    !(arb_arvalid_o && arb_awvalid_o)) else $error("read and write valid high together");

  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_data_ready_o |=> !mem_data_ready_o) else $error("completion held two cycles");

  a_arvalid_held: assert property (@(posedge clk) disable iff (rst)
    arb_arvalid_o && !rd_end |=> arb_arvalid_o) else $error("arvalid dropped mid burst");

  a_awvalid_held: assert property (@(posedge clk) disable iff (rst)
    arb_awvalid_o && !wr_end |=> arb_awvalid_o) else $error("awvalid dropped mid burst");

endmodule

bind dcache_ctrl dcache_props u_props (
  .clk(clk), .rst(rst), .state_o(state_o), .beat_o(beat_o), .arb_arvalid_o(arb_arvalid_o),
  .arb_awvalid_o(arb_awvalid_o), .arb_rvalid_i(arb_rvalid_i), .arb_wready_i(arb_wready_i),
  .mem_data_ready_o(mem_data_ready_o)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb import dcache_pkg::*; ();

  localparam logic [31:0] READ_KEY = 32'h5A5A_0000;  // unwritten word = address ^ key
  localparam logic [31:0] ADDR_A   = 32'h0000_1234;  // index 0x48, tag 0, word 13
  localparam logic [31:0] LINE_A   = 32'h0000_1200;
  localparam logic [31:0] ADDR_B   = 32'h0000_3234;  // same index, tag 1
  localparam logic [31:0] LINE_B   = 32'h0000_3200;
  localparam logic [31:0] UNC_BASE = 32'hA000_0100;  // io window
  localparam int          TIMEOUT  = 1000;           // cycles per wait

  logic        clk;
  logic        rst;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic [3:0]  mem_mask;
  mem_size_e   mem_size;
  logic        mem_addr_valid, mem_write_valid, mem_data_ready;
  logic [31:0] arb_araddr, arb_awaddr, arb_wdata;
  logic        arb_arvalid, arb_awvalid;
  logic [3:0]  arb_rsize, arb_wsize, arb_wmask;
  logic [7:0]  arb_rlen, arb_wlen;
  logic        arb_rvalid = 1'b0;
  logic        arb_wready = 1'b0;
  logic [31:0] arb_rdata  = '0;

  logic [31:0] lfsr   = 32'h67be;
  logic [31:0] rd_cnt = '0;  // beats taken in the current read burst
  logic [31:0] wr_cnt = '0;
  logic [31:0] wmem [logic [31:0]];  // words written by the dut
  logic [31:0] shadow [16];          // expected contents of line A
  logic [31:0] rd_addr_log[$], wr_addr_log[$], wr_data_log[$];
  logic [7:0]  rd_len_log[$], wr_len_log[$];
  logic [3:0]  rd_size_log[$], wr_size_log[$], wr_mask_log[$];
  int          port_busy = 0;  // cycles with either valid high
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  dcache_top u_dcache_top (
    .clk, .rst, .mem_addr_i(mem_addr), .mem_mask_i(mem_mask), .mem_size_i(mem_size),
    .mem_addr_valid_i(mem_addr_valid), .mem_write_valid_i(mem_write_valid),
    .mem_wdata_i(mem_wdata), .mem_rdata_o(mem_rdata), .mem_data_ready_o(mem_data_ready),
    .arb_araddr_o(arb_araddr), .arb_arvalid_o(arb_arvalid), .arb_rsize_o(arb_rsize),
    .arb_rlen_o(arb_rlen), .arb_rvalid_i(arb_rvalid), .arb_rdata_i(arb_rdata),
    .arb_awaddr_o(arb_awaddr), .arb_awvalid_o(arb_awvalid), .arb_wmask_o(arb_wmask),
    .arb_wsize_o(arb_wsize), .arb_wlen_o(arb_wlen), .arb_wready_i(arb_wready),
    .arb_wdata_o(arb_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 50 MHz
  end

  // galois lfsr stepped once per bit
  function automatic logic next_rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] model_word(logic [31:0] a);
    return wmem.exists(a) ? wmem[a] : (a ^ READ_KEY);
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] m);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (m[b]) r[8*b +: 8] = new_w[8*b +: 8];  // lane taken from the new word
    end
    return r;
  endfunction

  // zero extended byte or half picked by the low address bits
  function automatic logic [31:0] lane_value(logic [31:0] w, logic [31:0] a, mem_size_e s);
    if (s == SIZE_BYTE) return (w >> (8 * a[1:0])) & 32'h0000_00FF;
    if (s == SIZE_HALF) return (w >> (16 * a[1])) & 32'h0000_FFFF;
    return w;
  endfunction

  // memory model sampling handshakes mid cycle where everything is settled
  always @(negedge clk) begin
    logic [31:0] wbeat;
    wbeat = {arb_awaddr[31:2], 2'b00} + (wr_cnt << 2);
    if (arb_arvalid || arb_awvalid) port_busy++;
    if (arb_arvalid && arb_rvalid) begin
      rd_addr_log.push_back(arb_araddr);
      rd_len_log.push_back(arb_rlen);
      rd_size_log.push_back(arb_rsize);
    end
    rd_cnt = !arb_arvalid ? '0 : rd_cnt + {31'b0, arb_rvalid};
    if (arb_awvalid && arb_wready) begin
      wr_addr_log.push_back(wbeat);
      wr_data_log.push_back(arb_wdata);
      wr_mask_log.push_back(arb_wmask);
      wr_len_log.push_back(arb_wlen);
      wr_size_log.push_back(arb_wsize);
      wmem[wbeat] = merge_bytes(model_word(wbeat), arb_wdata, arb_wmask);  // later reads see it
    end
    wr_cnt = !arb_awvalid ? '0 : wr_cnt + {31'b0, arb_wready};
  end

  // back-pressure about one cycle in four and data for the next beat
  always @(posedge clk) begin
    #2;
    arb_rvalid = next_rand_bit() | next_rand_bit();
    arb_wready = next_rand_bit() | next_rand_bit();
    arb_rdata  = model_word({arb_araddr[31:2], 2'b00} + (rd_cnt << 2));
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_port_idle();
    check_value("arb_arvalid_o", 0, 32'(arb_arvalid));
    check_value("arb_awvalid_o", 0, 32'(arb_awvalid));
    check_value("mem_data_ready_o", 0, 32'(mem_data_ready));
  endtask

  // one cpu access entered 2 ns after a rising edge
  task automatic cpu_access(input logic [31:0] addr, input logic wr, input mem_size_e size,
                            input logic [3:0] mask, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited          = 0;
    mem_addr        = addr;
    mem_write_valid = wr;
    mem_size        = size;
    mem_mask        = mask;
    mem_wdata       = wdata;
    mem_addr_valid  = 1'b1;
    @(negedge clk);
    while (!mem_data_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!mem_data_ready) begin
      timeouts++;
      $display("ERROR at %0t: access to %h never completed", $time, addr);
    end
    rdata = mem_rdata;  // valid during the pulse
    @(posedge clk);
    #2;
    mem_addr_valid  = 1'b0;
    mem_write_valid = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic run_reset_test();
    repeat (16) begin
      @(posedge clk);
      #2;
      check_port_idle();
    end
    rst = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #2;
      check_port_idle();
    end
  endtask

  task automatic run_read_miss_test();
    logic [31:0] rdata;
    int          r0;
    int          busy0;
    r0 = rd_addr_log.size();
    cpu_access(ADDR_A, 1'b0, SIZE_WORD, 4'hf, '0, rdata);
    check_value("read beat count", `DC_BEATS, rd_addr_log.size() - r0);
    for (int i = r0; i < rd_addr_log.size(); i++) begin
      check_value("arb_araddr_o", LINE_A, rd_addr_log[i]);
      check_value("arb_rlen_o", `DC_BURST_LEN, 32'(rd_len_log[i]));
      check_value("arb_rsize_o", 32'(SIZE_WORD), 32'(rd_size_log[i]));
    end
    check_value("mem_rdata_o", ADDR_A ^ READ_KEY, rdata);
    busy0 = port_busy;
    cpu_access(ADDR_A + 32'd8, 1'b0, SIZE_WORD, 4'hf, '0, rdata);  // same line so a hit
    check_value("mem_rdata_o", (ADDR_A + 32'd8) ^ READ_KEY, rdata);
    check_value("memory busy cycles on hit", 0, port_busy - busy0);
  endtask

  task automatic run_write_hit_test();
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [3:0]  masks [16];
    int          busy0;
    busy0 = port_busy;
    @(negedge clk);  // mask bits drawn mid cycle
    for (int k = 0; k < 16; k++) begin
      for (int b = 0; b < 4; b++) begin
        masks[k][b] = next_rand_bit();
      end
    end
    @(posedge clk);
    #2;
    for (int k = 0; k < 16; k++) begin
      shadow[k] = (LINE_A + 32'(4 * k)) ^ READ_KEY;  // as refilled
      wdata     = ~shadow[k];  // every byte differs
      cpu_access(LINE_A + 32'(4 * k), 1'b1, SIZE_WORD, masks[k], wdata, rdata);
      shadow[k] = merge_bytes(shadow[k], wdata, masks[k]);
    end
    for (int k = 0; k < 16; k++) begin
      cpu_access(LINE_A + 32'(4 * k), 1'b0, SIZE_WORD, 4'hf, '0, rdata);
      check_value("mem_rdata_o", shadow[k], rdata);
    end
    check_value("memory busy cycles on write hits", 0, port_busy - busy0);
  endtask

  task automatic run_eviction_test();
    logic [31:0] rdata;
    int          r0;
    int          w0;
    w0 = wr_addr_log.size();
    r0 = rd_addr_log.size();
    cpu_access(ADDR_B, 1'b0, SIZE_WORD, 4'hf, '0, rdata);
    check_value("write back beat count", `DC_BEATS, wr_addr_log.size() - w0);
    for (int k = 0; k < 16 && w0 + k < wr_addr_log.size(); k++) begin
      check_value("arb_awaddr_o", LINE_A + 32'(4 * k), wr_addr_log[w0 + k]);
      check_value("arb_wdata_o", shadow[k], wr_data_log[w0 + k]);
      check_value("arb_wmask_o", 32'hF, 32'(wr_mask_log[w0 + k]));
      check_value("arb_wlen_o", `DC_BURST_LEN, 32'(wr_len_log[w0 + k]));
    end
    check_value("refill beat count", `DC_BEATS, rd_addr_log.size() - r0);
    if (rd_addr_log.size() > r0) check_value("arb_araddr_o", LINE_B, rd_addr_log[r0]);
    check_value("mem_rdata_o", ADDR_B ^ READ_KEY, rdata);
    w0 = wr_addr_log.size();
    cpu_access(ADDR_A, 1'b0, SIZE_WORD, 4'hf, '0, rdata);  // line B is clean
    check_value("mem_rdata_o", shadow[13], rdata);
    check_value("write back beat count", 0, wr_addr_log.size() - w0);
    cpu_access(LINE_A, 1'b0, SIZE_WORD, 4'hf, '0, rdata);
    check_value("mem_rdata_o", shadow[0], rdata);
  endtask

  task automatic unc_write_case(input logic [31:0] addr, input mem_size_e size,
                                input logic [31:0] wdata, input logic [3:0] strobe);
    logic [31:0] rdata;
    int          w0;
    w0 = wr_addr_log.size();
    cpu_access(addr, 1'b1, size, 4'hf, wdata, rdata);
    check_value("uncached write beat count", 1, wr_addr_log.size() - w0);
    if (wr_addr_log.size() > w0) begin
      check_value("arb_awaddr_o", {addr[31:2], 2'b00}, wr_addr_log[w0]);
      check_value("arb_wlen_o", 0, 32'(wr_len_log[w0]));
      check_value("arb_wsize_o", 32'(size), 32'(wr_size_log[w0]));
      check_value("arb_wmask_o", 32'(strobe), 32'(wr_mask_log[w0]));
    end
  endtask

  task automatic unc_read_case(input logic [31:0] addr, input mem_size_e size,
                               input logic [31:0] word);
    logic [31:0] rdata;
    int          r0;
    r0 = rd_addr_log.size();
    cpu_access(addr, 1'b0, size, 4'hf, '0, rdata);
    check_value("uncached read beat count", 1, rd_addr_log.size() - r0);
    if (rd_addr_log.size() > r0) begin
      check_value("arb_araddr_o", addr, rd_addr_log[r0]);  // exact byte address
      check_value("arb_rlen_o", 0, 32'(rd_len_log[r0]));
      check_value("arb_rsize_o", 32'(size), 32'(rd_size_log[r0]));
    end
    check_value("mem_rdata_o", lane_value(word, addr, size), rdata);
  endtask

  task automatic run_uncached_test();
    logic [31:0] merged;
    unc_write_case(UNC_BASE + 32'd1, SIZE_BYTE, 32'h0000_AB00, 4'b0010);
    unc_write_case(UNC_BASE + 32'd2, SIZE_HALF, 32'hCDEF_0000, 4'b1100);
    unc_write_case(UNC_BASE + 32'd8, SIZE_WORD, 32'h1357_9BDF, 4'b1111);
    merged = merge_bytes(UNC_BASE ^ READ_KEY, 32'h0000_AB00, 4'b0010);
    merged = merge_bytes(merged, 32'hCDEF_0000, 4'b1100);
    unc_read_case(UNC_BASE, SIZE_WORD, merged);
    unc_read_case(UNC_BASE + 32'd9, SIZE_BYTE, 32'h1357_9BDF);
    unc_read_case(UNC_BASE + 32'h43, SIZE_BYTE, (UNC_BASE + 32'h40) ^ READ_KEY);
    unc_read_case(UNC_BASE + 32'h46, SIZE_HALF, (UNC_BASE + 32'h44) ^ READ_KEY);
    unc_read_case(UNC_BASE + 32'h48, SIZE_WORD, (UNC_BASE + 32'h48) ^ READ_KEY);
  endtask

  initial begin
    rst             = 1'b1;
    mem_addr        = '0;
    mem_mask        = '0;
    mem_size        = SIZE_WORD;
    mem_addr_valid  = 1'b0;
    mem_write_valid = 1'b0;
    mem_wdata       = '0;
    run_reset_test();
    run_read_miss_test();
    run_write_hit_test();
    run_eviction_test();
    run_uncached_test();
    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
